/* rtl/mem_pkg.sv */
package mem_pkg;

  localparam int word_w = 64;
  localparam int lane_w = 3;  // byte offset inside a word

  typedef enum logic [1:0] {
    sz_byte,
    sz_half,
    sz_word,
    sz_dword
  } mem_size_e;

  // one memory word seen as lanes of each access size
  typedef union packed {
    logic [word_w-1:0]      d;
    logic [1:0][31:0]       w;
    logic [3:0][15:0]       h;
    logic [7:0][7:0]        b;
  } mem_word_u;

endpackage

/* rtl/core_pkg.sv */
package core_pkg;

  localparam int xlen      = 64;
  localparam int reg_idx_w = 5;

  // writeback source
  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_imm,
    wb_snxt_pc
  } wb_sel_e;

  // ****************************************
  // one item from the execute stage
  // ****************************************
  typedef struct packed {
    logic [reg_idx_w-1:0] rd;
    logic                 wb_en;
    wb_sel_e              wb_sel;
    logic [xlen-1:0]      alu_result;   // also the load/store address
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      snxt_pc;
    logic [xlen-1:0]      store_data;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      branch_pc;
    logic                 load_en;
    logic                 store_en;
    mem_pkg::mem_size_e   size;
    logic                 load_unsigned;
    logic                 jump_en;
    logic                 branch_en;
    logic                 branch_taken;
    logic                 ebreak;
  } exu_item_t;

endpackage

/* rtl/dmem_if.sv */
`timescale 1ns/1ns

interface dmem_if;
  logic [core_pkg::xlen-1:0]   addr;
  logic [core_pkg::xlen-1:0]   wdata;
  logic [core_pkg::xlen/8-1:0] be;    // byte enables
  logic                        wen;
  logic                        ren;
  logic [core_pkg::xlen-1:0]   rdata;

  modport master (output addr, wdata, be, wen, ren, input rdata);
  modport slave (input addr, wdata, be, wen, ren, output rdata);
  modport slave_rd (input rdata);   // writeback side only sees read data
endinterface

/* rtl/mem_wb_if.sv */
`timescale 1ns/1ns

interface mem_wb_if;
  logic                           valid;
  logic [core_pkg::reg_idx_w-1:0] rd;
  logic                           wb_en;
  core_pkg::wb_sel_e              wb_sel;
  logic [core_pkg::xlen-1:0]      alu_result;
  logic [core_pkg::xlen-1:0]      imm;
  logic [core_pkg::xlen-1:0]      snxt_pc;
  logic [core_pkg::xlen-1:0]      pc;
  logic                           is_load;
  mem_pkg::mem_size_e             size;
  logic                           load_unsigned;
  logic [mem_pkg::lane_w-1:0]     offset;
  logic                           ebreak;

  modport source (output valid, rd, wb_en, wb_sel, alu_result, imm, snxt_pc, pc,
                  is_load, size, load_unsigned, offset, ebreak);
  modport sink (input valid, rd, wb_en, wb_sel, alu_result, imm, snxt_pc, pc,
                is_load, size, load_unsigned, offset, ebreak);
endinterface

/* rtl/exu_queue.sv */
`timescale 1ns/1ns

module exu_queue #(
  parameter int DEPTH = 4
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                push,
  input  core_pkg::exu_item_t push_item,
  input  logic                pop,
  output logic                head_valid,
  output core_pkg::exu_item_t head,
  output logic                credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  core_pkg::exu_item_t slots [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head_valid = (count != '0);
  assign head       = slots[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) slots[wr_ptr] <= push_item;  // upstream credits guarantee room
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop;  // one credit back per pop
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage #(
  parameter int OUT_CREDITS = 2
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      head_valid,
  input  core_pkg::exu_item_t       head,
  input  logic                      out_credit,
  output logic                      pop,
  output logic                      redirect_valid,
  output logic [core_pkg::xlen-1:0] redirect_pc,
  dmem_if.master                    dmem,
  mem_wb_if.source                  wb
);

  localparam int CR_W = $clog2(OUT_CREDITS + 1);

  logic [CR_W-1:0]               credits;
  logic                          issue;
  logic [mem_pkg::lane_w-1:0]    offset;
  mem_pkg::mem_word_u            store_word;
  logic [core_pkg::xlen/8-1:0]   store_be;

  assign issue  = head_valid && (credits != '0);
  assign pop    = issue;
  assign offset = head.alu_result[mem_pkg::lane_w-1:0];

  // output slots held by downstream
  always_ff @(posedge clk) begin
    if (!rstn) credits <= CR_W'(OUT_CREDITS);
    else if (issue && !out_credit) credits <= credits - 1'b1;
    else if (!issue && out_credit) credits <= credits + 1'b1;
  end

  // ****************************************
  // store lanes and byte enables
  // ****************************************
  always_comb begin
    store_word.d = head.store_data;
    store_be     = 8'hff;
    case (head.size)
      mem_pkg::sz_byte: begin
        store_word.b = {8{head.store_data[7:0]}};
        store_be     = 8'h01 << offset;
      end
      mem_pkg::sz_half: begin
        store_word.h = {4{head.store_data[15:0]}};
        store_be     = 8'h03 << offset;
      end
      mem_pkg::sz_word: begin
        store_word.w = {2{head.store_data[31:0]}};
        store_be     = 8'h0f << offset;
      end
      default: store_be = 8'hff;  // dword fills the word
    endcase
  end

  assign dmem.addr  = head.alu_result;
  assign dmem.wdata = store_word.d;
  assign dmem.be    = store_be;
  assign dmem.wen   = issue && head.store_en;
  assign dmem.ren   = issue && head.load_en;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wb.valid       <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      wb.valid       <= issue;
      redirect_valid <= issue && (head.jump_en || (head.branch_en && head.branch_taken));
    end
  end

  // payload for writeback
  always_ff @(posedge clk) begin
    if (issue) begin
      wb.rd            <= head.rd;
      wb.wb_en         <= head.wb_en;
      wb.wb_sel        <= head.wb_sel;
      wb.alu_result    <= head.alu_result;
      wb.imm           <= head.imm;
      wb.snxt_pc       <= head.snxt_pc;
      wb.pc            <= head.pc;
      wb.is_load       <= head.load_en;
      wb.size          <= head.size;
      wb.load_unsigned <= head.load_unsigned;
      wb.offset        <= offset;
      wb.ebreak        <= head.ebreak;
      redirect_pc      <= head.jump_en ? head.alu_result : head.branch_pc;
    end
  end

endmodule

/* rtl/dmem.sv */
`timescale 1ns/1ns

module dmem #(
  parameter int MEM_WORDS = 256
) (
  input  logic clk,
  input  logic rstn,
  dmem_if.slave mem
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int BYTES = core_pkg::xlen / 8;

  logic [core_pkg::xlen-1:0] ram [MEM_WORDS];
  logic [IDX_W-1:0]          idx;

  assign idx = mem.addr[mem_pkg::lane_w +: IDX_W];  // word address

  // byte write
  always_ff @(posedge clk) begin
    if (mem.wen) begin
      for (int i = 0; i < BYTES; i++) begin
        if (mem.be[i]) ram[idx][8*i +: 8] <= mem.wdata[8*i +: 8];
      end
    end
  end

  // read data one cycle after ren
  always_ff @(posedge clk) begin
    if (!rstn) mem.rdata <= '0;
    else if (mem.ren) mem.rdata <= ram[idx];
  end

endmodule

/* rtl/wb_stage.sv */
`timescale 1ns/1ns

module wb_stage (
  input  logic                           clk,
  input  logic                           rstn,
  mem_wb_if.sink                         wb,
  dmem_if.slave_rd                       rdata,
  output logic                           wb_valid,
  output logic                           wb_en,
  output logic                           wb_ebreak,
  output logic [core_pkg::reg_idx_w-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]      wb_data,
  output logic [core_pkg::xlen-1:0]      wb_pc
);

  mem_pkg::mem_word_u        rd_word;
  logic [7:0]                lane_b;
  logic [15:0]               lane_h;
  logic [31:0]               lane_wd;
  logic [core_pkg::xlen-1:0] load_ext;
  logic [core_pkg::xlen-1:0] load_data;
  logic [core_pkg::xlen-1:0] wb_value;

  // ****************************************
  // load lane pick and extension
  // ****************************************
  assign rd_word = mem_pkg::mem_word_u'(rdata.rdata);
  assign lane_b  = rd_word.b[wb.offset];
  assign lane_h  = rd_word.h[wb.offset[2:1]];
  assign lane_wd = rd_word.w[wb.offset[2]];

  always_comb begin
    case (wb.size)
      mem_pkg::sz_byte: load_ext = wb.load_unsigned ? {56'b0, lane_b} : {{56{lane_b[7]}}, lane_b};
      mem_pkg::sz_half: load_ext = wb.load_unsigned ? {48'b0, lane_h} : {{48{lane_h[15]}}, lane_h};
      mem_pkg::sz_word: load_ext = wb.load_unsigned ? {32'b0, lane_wd}
                                                    : {{32{lane_wd[31]}}, lane_wd};
      default:          load_ext = rd_word.d;
    endcase
  end

  assign load_data = wb.is_load ? load_ext : '0;  // no stale word for non-loads

  always_comb begin
    case (wb.wb_sel)
      core_pkg::wb_load:    wb_value = load_data;
      core_pkg::wb_imm:     wb_value = wb.imm;
      core_pkg::wb_snxt_pc: wb_value = wb.snxt_pc;
      default:              wb_value = wb.alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) wb_valid <= 1'b0;
    else wb_valid <= wb.valid;
  end

  always_ff @(posedge clk) begin
    if (wb.valid) begin
      wb_en     <= wb.wb_en;
      wb_ebreak <= wb.ebreak;
      wb_rd     <= wb.rd;
      wb_data   <= wb_value;
      wb_pc     <= wb.pc;
    end
  end

endmodule

/* rtl/mem_backend.sv */
`timescale 1ns/1ns

module mem_backend #(
  parameter int DEPTH       = 4,
  parameter int OUT_CREDITS = 2,
  parameter int MEM_WORDS   = 256
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           in_valid,
  input  logic [core_pkg::reg_idx_w-1:0] in_rd,
  input  logic                           in_wb_en,
  input  logic [1:0]                     in_wb_sel,
  input  logic [core_pkg::xlen-1:0]      in_alu_result,
  input  logic [core_pkg::xlen-1:0]      in_imm,
  input  logic [core_pkg::xlen-1:0]      in_snxt_pc,
  input  logic [core_pkg::xlen-1:0]      in_store_data,
  input  logic [core_pkg::xlen-1:0]      in_pc,
  input  logic [core_pkg::xlen-1:0]      in_branch_pc,
  input  logic                           in_load_en,
  input  logic                           in_store_en,
  input  logic [1:0]                     in_size,
  input  logic                           in_load_unsigned,
  input  logic                           in_jump_en,
  input  logic                           in_branch_en,
  input  logic                           in_branch_taken,
  input  logic                           in_ebreak,
  output logic                           in_credit,
  output logic                           wb_valid,
  output logic                           wb_en,
  output logic [core_pkg::reg_idx_w-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]      wb_data,
  output logic [core_pkg::xlen-1:0]      wb_pc,
  output logic                           wb_ebreak,
  input  logic                           out_credit,
  output logic                           redirect_valid,
  output logic [core_pkg::xlen-1:0]      redirect_pc
);

  core_pkg::exu_item_t in_item;
  core_pkg::exu_item_t head;
  logic                head_valid;
  logic                pop;

  dmem_if   dmem_bus ();
  mem_wb_if mem_wb ();

  // flat ports into one item
  assign in_item = '{
    rd:            in_rd,
    wb_en:         in_wb_en,
    wb_sel:        core_pkg::wb_sel_e'(in_wb_sel),
    alu_result:    in_alu_result,
    imm:           in_imm,
    snxt_pc:       in_snxt_pc,
    store_data:    in_store_data,
    pc:            in_pc,
    branch_pc:     in_branch_pc,
    load_en:       in_load_en,
    store_en:      in_store_en,
    size:          mem_pkg::mem_size_e'(in_size),
    load_unsigned: in_load_unsigned,
    jump_en:       in_jump_en,
    branch_en:     in_branch_en,
    branch_taken:  in_branch_taken,
    ebreak:        in_ebreak
  };

  exu_queue #(.DEPTH(DEPTH)) i_exu_queue (
    .clk        (clk),
    .rstn       (rstn),
    .push       (in_valid),
    .push_item  (in_item),
    .pop        (pop),
    .head_valid (head_valid),
    .head       (head),
    .credit     (in_credit)
  );

  mem_stage #(.OUT_CREDITS(OUT_CREDITS)) i_mem_stage (
    .clk            (clk),
    .rstn           (rstn),
    .head_valid     (head_valid),
    .head           (head),
    .out_credit     (out_credit),
    .pop            (pop),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .dmem           (dmem_bus.master),
    .wb             (mem_wb.source)
  );

  dmem #(.MEM_WORDS(MEM_WORDS)) i_dmem (
    .clk  (clk),
    .rstn (rstn),
    .mem  (dmem_bus.slave)
  );

  wb_stage i_wb_stage (
    .clk       (clk),
    .rstn      (rstn),
    .wb        (mem_wb.sink),
    .rdata     (dmem_bus.slave_rd),
    .wb_valid  (wb_valid),
    .wb_en     (wb_en),
    .wb_ebreak (wb_ebreak),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .wb_pc     (wb_pc)
  );

endmodule

/* bench/tb_mem_backend.sv */
`timescale 1ns/1ns

module tb_mem_backend;

  localparam int DEPTH       = 4;
  localparam int OUT_CREDITS = 2;
  localparam int MEM_WORDS   = 256;
  localparam int XLEN        = core_pkg::xlen;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            redir;
    logic [XLEN-1:0] pc;
  } ref_t;

  typedef struct packed {
    core_pkg::exu_item_t item;
    logic [XLEN-1:0]     data;
  } wb_exp_t;

  logic                           clk;
  logic                           rstn;
  logic                           in_valid;
  logic [core_pkg::reg_idx_w-1:0] in_rd;
  logic                           in_wb_en;
  logic [1:0]                     in_wb_sel;
  logic [XLEN-1:0]                in_alu_result;
  logic [XLEN-1:0]                in_imm;
  logic [XLEN-1:0]                in_snxt_pc;
  logic [XLEN-1:0]                in_store_data;
  logic [XLEN-1:0]                in_pc;
  logic [XLEN-1:0]                in_branch_pc;
  logic                           in_load_en;
  logic                           in_store_en;
  logic [1:0]                     in_size;
  logic                           in_load_unsigned;
  logic                           in_jump_en;
  logic                           in_branch_en;
  logic                           in_branch_taken;
  logic                           in_ebreak;
  logic                           in_credit;
  logic                           wb_valid;
  logic                           wb_en;
  logic [core_pkg::reg_idx_w-1:0] wb_rd;
  logic [XLEN-1:0]                wb_data;
  logic [XLEN-1:0]                wb_pc;
  logic                           wb_ebreak;
  logic                           out_credit;
  logic                           redirect_valid;
  logic [XLEN-1:0]                redirect_pc;

  core_pkg::exu_item_t items [$];
  wb_exp_t             exp_q [$];
  logic [XLEN-1:0]     redir_q [$];
  logic [XLEN-1:0]     ref_mem [MEM_WORDS];
  int                  due_q [$];
  wb_exp_t             head_exp;
  int                  n_items;
  int                  limit;
  int                  cycles;
  int                  checked;
  int                  credit_seen;
  int                  in_cred;
  int                  sent;
  int                  out_slots;
  int                  beats;
  int                  now;

  mem_backend #(.DEPTH(DEPTH), .OUT_CREDITS(OUT_CREDITS), .MEM_WORDS(MEM_WORDS)) i_mem_backend (
    .clk (clk), .rstn (rstn), .in_valid (in_valid), .in_rd (in_rd), .in_wb_en (in_wb_en),
    .in_wb_sel (in_wb_sel), .in_alu_result (in_alu_result), .in_imm (in_imm),
    .in_snxt_pc (in_snxt_pc), .in_store_data (in_store_data), .in_pc (in_pc),
    .in_branch_pc (in_branch_pc), .in_load_en (in_load_en), .in_store_en (in_store_en),
    .in_size (in_size), .in_load_unsigned (in_load_unsigned), .in_jump_en (in_jump_en),
    .in_branch_en (in_branch_en), .in_branch_taken (in_branch_taken), .in_ebreak (in_ebreak),
    .in_credit (in_credit), .wb_valid (wb_valid), .wb_en (wb_en), .wb_rd (wb_rd),
    .wb_data (wb_data), .wb_pc (wb_pc), .wb_ebreak (wb_ebreak), .out_credit (out_credit),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // ****************************************
  // reference model
  // ****************************************
  function automatic ref_t ref_wb(input core_pkg::exu_item_t it, input logic [XLEN-1:0] word);
    ref_t            r;
    logic [XLEN-1:0] lane;
    logic [XLEN-1:0] mask;
    int              nb;
    nb   = 1 << it.size;
    mask = (nb == 8) ? '1 : (64'd1 << (8 * nb)) - 64'd1;
    lane = (word >> (8 * it.alu_result[2:0])) & mask;
    if (!it.load_unsigned && lane[8 * nb - 1]) lane = lane | ~mask;  // sign fill
    case (it.wb_sel)
      core_pkg::wb_load:    r.data = it.load_en ? lane : '0;
      core_pkg::wb_imm:     r.data = it.imm;
      core_pkg::wb_snxt_pc: r.data = it.snxt_pc;
      default:              r.data = it.alu_result;
    endcase
    r.redir = it.jump_en || (it.branch_en && it.branch_taken);
    r.pc    = it.jump_en ? it.alu_result : it.branch_pc;
    return r;
  endfunction

  task automatic apply_store(input core_pkg::exu_item_t it);
    int nb;
    int off;
    nb  = 1 << it.size;
    off = it.alu_result[2:0];
    for (int i = 0; i < nb; i++) begin
      ref_mem[it.alu_result[10:3]][8*(off+i) +: 8] = it.store_data[8*i +: 8];
    end
  endtask

  // ****************************************
  // stimulus
  // ****************************************
  function automatic core_pkg::exu_item_t rand_item();
    core_pkg::exu_item_t it;
    it            = '0;
    it.rd         = 5'($urandom_range(0, 31));
    it.wb_en      = 1'b1;
    it.alu_result = {$urandom, $urandom};
    it.imm        = {$urandom, $urandom};
    it.snxt_pc    = {$urandom, $urandom};
    it.store_data = {$urandom, $urandom};
    it.pc         = {$urandom, $urandom};
    it.branch_pc  = {$urandom, $urandom};
    it.ebreak     = ($urandom_range(0, 9) == 0);
    return it;
  endfunction

  function automatic core_pkg::exu_item_t mem_item(input core_pkg::exu_item_t it,
                                                   input logic is_load, input int s,
                                                   input int word, input int off);
    it.alu_result = 64'(word * 8 + off);
    it.size       = mem_pkg::mem_size_e'(s);
    if (is_load) begin
      it.load_en       = 1'b1;
      it.wb_sel        = core_pkg::wb_load;
      it.load_unsigned = $urandom_range(0, 1);
    end else begin
      it.store_en = 1'b1;
      it.wb_en    = 1'b0;
    end
    return it;
  endfunction

  // kinds 0..7 are alu, imm, next pc, jump, taken, not taken, store, load
  function automatic core_pkg::exu_item_t make_item(input int kind);
    core_pkg::exu_item_t it;
    int                  s;
    it = rand_item();
    s  = $urandom_range(0, 3);
    case (kind)
      1: it.wb_sel = core_pkg::wb_imm;
      2: it.wb_sel = core_pkg::wb_snxt_pc;
      3: begin
        it.jump_en = 1'b1;
        it.wb_sel  = core_pkg::wb_snxt_pc;
      end
      4, 5: begin
        it.branch_en    = 1'b1;
        it.branch_taken = (kind == 4);
      end
      6, 7: it = mem_item(it, kind == 7, s, $urandom_range(16, 19),
                          $urandom_range(0, 7) & ~((1 << s) - 1));
      default: it.wb_sel = core_pkg::wb_alu;
    endcase
    return it;
  endfunction

  task automatic build_items();
    core_pkg::exu_item_t it;
    for (int k = 0; k < 18; k++) begin
      items.push_back(make_item(k % 6));
    end
    // words 16..19 filled by bytes, halves, words, one dword
    for (int s = 0; s < 4; s++) begin
      for (int o = 0; o < 8; o += 1 << s) begin
        items.push_back(mem_item(rand_item(), 1'b0, s, 16 + s, o));
      end
    end
    for (int w = 0; w < 4; w++) begin
      for (int s = 0; s < 4; s++) begin
        for (int o = 0; o < 8; o += 1 << s) begin
          for (int u = 0; u < 2; u++) begin
            it = mem_item(rand_item(), 1'b1, s, 16 + w, o);
            it.load_unsigned = u[0];
            items.push_back(it);
          end
        end
      end
    end
    for (int k = 0; k < 60; k++) begin
      items.push_back(make_item($urandom_range(0, 7)));
    end
  endtask

  task automatic send_item(input core_pkg::exu_item_t it);
    ref_t    r;
    wb_exp_t e;
    r      = ref_wb(it, ref_mem[it.alu_result[10:3]]);
    e.item = it;
    e.data = r.data;
    exp_q.push_back(e);
    if (r.redir) redir_q.push_back(r.pc);
    if (it.store_en) apply_store(it);
    in_rd            = it.rd;
    in_wb_en         = it.wb_en;
    in_wb_sel        = it.wb_sel;
    in_alu_result    = it.alu_result;
    in_imm           = it.imm;
    in_snxt_pc       = it.snxt_pc;
    in_store_data    = it.store_data;
    in_pc            = it.pc;
    in_branch_pc     = it.branch_pc;
    in_load_en       = it.load_en;
    in_store_en      = it.store_en;
    in_size          = it.size;
    in_load_unsigned = it.load_unsigned;
    in_jump_en       = it.jump_en;
    in_branch_en     = it.branch_en;
    in_branch_taken  = it.branch_taken;
    in_ebreak        = it.ebreak;
    in_valid         = 1'b1;
  endtask

  // ****************************************
  // compare tasks
  // ****************************************
  task automatic check_wb(input core_pkg::exu_item_t it, input logic [XLEN-1:0] data);
    if (wb_data !== data)
      stop_run($sformatf("mismatch at %0t: wb_data got %h expected %h", $time, wb_data, data));
    if (wb_rd !== it.rd)
      stop_run($sformatf("mismatch at %0t: wb_rd got %0d expected %0d", $time, wb_rd, it.rd));
    if (wb_en !== it.wb_en)
      stop_run($sformatf("mismatch at %0t: wb_en got %b expected %b", $time, wb_en, it.wb_en));
    if (wb_pc !== it.pc)
      stop_run($sformatf("mismatch at %0t: wb_pc got %h expected %h", $time, wb_pc, it.pc));
    if (wb_ebreak !== it.ebreak)
      stop_run($sformatf("mismatch at %0t: wb_ebreak got %b expected %b",
                         $time, wb_ebreak, it.ebreak));
  endtask

  task automatic check_redirect(input logic [XLEN-1:0] pc);
    if (redirect_pc !== pc)
      stop_run($sformatf("mismatch at %0t: redirect_pc got %h expected %h",
                         $time, redirect_pc, pc));
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) stop_run("timeout: writeback traffic did not drain in time");
    if (in_credit === 1'b1) credit_seen++;
    if (wb_valid === 1'b1) begin
      if (exp_q.size() == 0) stop_run("writeback beat with no item outstanding");
      head_exp = exp_q.pop_front();
      check_wb(head_exp.item, head_exp.data);
      checked++;
    end
    if (redirect_valid === 1'b1) begin
      if (redir_q.size() == 0) stop_run("redirect with no jump or taken branch outstanding");
      check_redirect(redir_q.pop_front());
    end
  end

  // downstream slots with every 16th beat held back long
  initial begin
    out_credit = 1'b0;
    out_slots  = OUT_CREDITS;
    forever begin
      @(posedge clk);
      now++;
      if (wb_valid === 1'b1) begin
        out_slots--;
        if (out_slots < 0) stop_run("writeback beat sent without an output slot");
        beats++;
        due_q.push_back(now + ((beats % 16 == 0) ? 40 : $urandom_range(0, 6)));
      end
      #2;
      out_credit = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= now) begin
        void'(due_q.pop_front());
        out_credit = 1'b1;
        out_slots++;
      end
    end
  end

  initial begin
    void'($urandom(32'h1d846c79));
    rstn     = 1'b0;
    in_valid = 1'b0;
    send_item('0);  // zero every in_ port
    in_valid = 1'b0;
    exp_q.delete();
    build_items();
    n_items = items.size();
    limit   = 40 * n_items + 200;
    repeat (4) @(posedge clk);
    #2;
    rstn    = 1'b1;
    in_cred = DEPTH;
    while (sent < n_items) begin
      @(posedge clk);
      if (in_credit === 1'b1) in_cred++;
      if (in_cred > DEPTH) stop_run("more input credits returned than queue entries");
      #2;
      in_valid = 1'b0;
      if (in_cred > 0 && $urandom_range(0, 3) != 0) begin
        send_item(items[sent]);
        sent++;
        in_cred--;
      end
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    wait (checked == n_items);
    repeat (8) @(posedge clk);
    if (credit_seen != n_items || redir_q.size() != 0) begin
      stop_run("input credits or redirects left unbalanced after drain");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* sim.f */
rtl/mem_pkg.sv
rtl/core_pkg.sv
rtl/dmem_if.sv
rtl/mem_wb_if.sv
rtl/exu_queue.sv
rtl/mem_stage.sv
rtl/dmem.sv
rtl/wb_stage.sv
rtl/mem_backend.sv
bench/tb_mem_backend.sv
